/* filelist.f */
+incdir+include
logic/gpio_pkg.sv
logic/reset_sync.sv
logic/gpio_regs.sv
logic/gpio.sv
tb/tb_gpio.sv

/* Bender.yml */
package:
  name: gpio

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/gpio_pkg.sv
      - logic/reset_sync.sv
      - logic/gpio_regs.sv
      - logic/gpio.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_gpio.sv

/* tb/tb_gpio.sv */
/* GPIO testbench that drives the APB port, pads and peripheral inputs
   and checks the pad mux, input routing and registers against a model */

module tb_gpio;

	`include "gpio_pinmap.svh"

	localparam int N = gpio_pkg::N_PADS;

	// Room for the roughly 2100 cycles of tests
	localparam int MAX_CYCLES = 4000;

	logic clk;
	logic rst_n;

	// APB
	logic                psel;
	logic                penable;
	logic                pwrite;
	gpio_pkg::apb_addr_t paddr;
	gpio_pkg::apb_data_t pwdata;
	gpio_pkg::apb_data_t prdata;
	logic                pready;
	logic                pslverr;

	// Pads and peripherals
	gpio_pkg::pad_vec_t padout;
	gpio_pkg::pad_vec_t padoe;
	gpio_pkg::pad_vec_t padin;
	logic               lcd_pwm;
	logic               uart_tx;
	logic               spi_sclk;
	logic               spi_cs;
	logic               spi_sdo;
	logic               uart_rx;
	logic               spi_sdi;

	// Model copies of the software registers
	gpio_pkg::pad_vec_t model_out;
	gpio_pkg::pad_vec_t model_dir;
	gpio_pkg::pad_vec_t model_fsel;

	logic [15:0]         lfsr_state;
	int                  cycles = 0;
	logic                checking;
	logic [2*N-1:0]      exp_pads;
	gpio_pkg::apb_data_t rd;
	gpio_pkg::pad_vec_t  pin;
	logic                rx_before;

	gpio dut0 (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.pwdata_i   (pwdata),
		.prdata_o   (prdata),
		.pready_o   (pready),
		.pslverr_o  (pslverr),
		.padout_o   (padout),
		.padoe_o    (padoe),
		.padin_i    (padin),
		.lcd_pwm_i  (lcd_pwm),
		.uart_tx_i  (uart_tx),
		.spi_sclk_i (spi_sclk),
		.spi_cs_i   (spi_cs),
		.spi_sdo_i  (spi_sdo),
		.uart_rx_o  (uart_rx),
		.spi_sdi_o  (spi_sdi)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	// One LFSR step per bit
	function automatic gpio_pkg::apb_data_t rand_word(input int n);
		gpio_pkg::apb_data_t v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// Expected pads as {padoe, padout}
	function automatic logic [2*N-1:0] ref_pads(
		input gpio_pkg::pad_vec_t out_v,
		input gpio_pkg::pad_vec_t dir_v,
		input gpio_pkg::pad_vec_t fsel_v,
		input logic               tx,
		input logic               cs,
		input logic               sclk,
		input logic               mosi,
		input logic               pwm
	);
		gpio_pkg::pad_vec_t po;
		gpio_pkg::pad_vec_t oe;
		for (int i = 0; i < N; i++) begin
			if (!fsel_v[i]) begin
				po[i] = out_v[i];
				oe[i] = dir_v[i];
			end else begin
				oe[i] = 1'b1;
				if (i == PIN_UART_TX) begin
					po[i] = tx;
				end else if (i == PIN_FLASH_CS) begin
					po[i] = cs;
				end else if (i == PIN_FLASH_SCLK) begin
					po[i] = sclk;
				end else if (i == PIN_FLASH_MOSI) begin
					po[i] = mosi;
				end else if (i == PIN_LCD_PWM) begin
					po[i] = pwm;
				end else begin
					// RX, MISO and spare pads are inputs when selected
					po[i] = 1'b0;
					oe[i] = 1'b0;
				end
			end
		end
		return {oe, po};
	endfunction

	// Error response expected from the register map
	function automatic logic expect_err(input gpio_pkg::apb_addr_t addr, input logic wr);
		if (addr == gpio_pkg::ADDR_OUT || addr == gpio_pkg::ADDR_DIR ||
			addr == gpio_pkg::ADDR_FSEL) begin
			return 1'b0;
		end else if (addr == gpio_pkg::ADDR_IN) begin
			return wr;
		end
		return 1'b1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic wait_ready();
		@(negedge clk);
		while (pready !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic apb_write(input gpio_pkg::apb_addr_t addr, input gpio_pkg::apb_data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		wait_ready();
		check_value("pslverr_o", pslverr, expect_err(addr, 1'b1));
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		// Registers take the new value at this edge
		if (!expect_err(addr, 1'b1)) begin
			if (addr == gpio_pkg::ADDR_OUT) begin
				model_out = data[N-1:0];
			end else if (addr == gpio_pkg::ADDR_DIR) begin
				model_dir = data[N-1:0];
			end else if (addr == gpio_pkg::ADDR_FSEL) begin
				model_fsel = data[N-1:0];
			end
		end
	endtask

	task automatic apb_read(input gpio_pkg::apb_addr_t addr, output gpio_pkg::apb_data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		wait_ready();
		check_value("pslverr_o", pslverr, expect_err(addr, 1'b0));
		data = prdata;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input gpio_pkg::apb_addr_t addr, input gpio_pkg::apb_data_t exp);
		gpio_pkg::apb_data_t data;
		apb_read(addr, data);
		check_value("prdata_o", data, exp);
	endtask

	// Called at a rising edge
	task automatic drive_periph();
		uart_tx  <= lfsr_bit();
		spi_cs   <= lfsr_bit();
		spi_sclk <= lfsr_bit();
		spi_sdo  <= lfsr_bit();
		lcd_pwm  <= lfsr_bit();
	endtask

	// Pad mux and MISO routing checked between edges
	always @(negedge clk) begin
		if (checking) begin
			exp_pads = ref_pads(model_out, model_dir, model_fsel,
				uart_tx, spi_cs, spi_sclk, spi_sdo, lcd_pwm);
			check_value("padout_o", padout, exp_pads[N-1:0]);
			check_value("padoe_o", padoe, exp_pads[2*N-1:N]);
			check_value("spi_sdi_o", spi_sdi, padin[PIN_FLASH_MISO]);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$fatal(1);
		end
	end

	initial begin
		psel       <= 1'b0;
		penable    <= 1'b0;
		pwrite     <= 1'b0;
		paddr      <= '0;
		pwdata     <= '0;
		padin      <= '0;
		lcd_pwm    <= 1'b0;
		uart_tx    <= 1'b0;
		spi_sclk   <= 1'b0;
		spi_cs     <= 1'b0;
		spi_sdo    <= 1'b0;
		rst_n      <= 1'b0;
		lfsr_state = 16'd98;
		model_out  = '0;
		model_dir  = '0;
		model_fsel = '0;
		checking   = 1'b0;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// Synchronizer releases two edges later
		repeat (2) @(posedge clk);
		checking = 1'b1;

		// Reset state
		@(negedge clk);
		check_value("padoe_o", padoe, '0);
		read_expect(gpio_pkg::ADDR_OUT, '0);
		read_expect(gpio_pkg::ADDR_DIR, '0);
		read_expect(gpio_pkg::ADDR_FSEL, '0);

		// Software GPIO with random upper data bits
		for (int i = 0; i < 100; i++) begin
			apb_write(gpio_pkg::ADDR_OUT, rand_word(32));
			apb_write(gpio_pkg::ADDR_DIR, rand_word(32));
			read_expect(gpio_pkg::ADDR_OUT, model_out);
			read_expect(gpio_pkg::ADDR_DIR, model_dir);
		end

		// Peripheral functions with toggling levels
		for (int i = 0; i < 60; i++) begin
			apb_write(gpio_pkg::ADDR_FSEL, rand_word(32));
			repeat (4) begin
				@(posedge clk);
				drive_periph();
			end
			read_expect(gpio_pkg::ADDR_FSEL, model_fsel);
		end
		apb_write(gpio_pkg::ADDR_FSEL, 32'hFFFF_FFFF);
		repeat (8) begin
			@(posedge clk);
			drive_periph();
		end

		// IN read-back with UART RX one cycle late and MISO direct
		for (int i = 0; i < 50; i++) begin
			@(posedge clk);
			pin = gpio_pkg::pad_vec_t'(rand_word(N));
			rx_before = padin[PIN_UART_RX];
			padin <= pin;
			@(negedge clk);
			check_value("spi_sdi_o", spi_sdi, pin[PIN_FLASH_MISO]);
			check_value("uart_rx_o", uart_rx, rx_before);
			@(negedge clk);
			check_value("uart_rx_o", uart_rx, pin[PIN_UART_RX]);
			read_expect(gpio_pkg::ADDR_IN, pin);
		end

		// Bad accesses
		apb_write(16'h0010, rand_word(32));
		apb_read(16'h0010, rd);
		apb_write(gpio_pkg::ADDR_IN, rand_word(32));
		read_expect(gpio_pkg::ADDR_OUT, model_out);
		read_expect(gpio_pkg::ADDR_DIR, model_dir);
		read_expect(gpio_pkg::ADDR_FSEL, model_fsel);
		read_expect(gpio_pkg::ADDR_IN, padin);

		repeat (2) @(negedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

/* logic/gpio.sv */
/* GPIO top: pad mux between software GPIO and fixed peripherals,
   pad input snapshot and routing of the peripheral inputs */

module gpio (
	input  logic                clk,
	input  logic                rst_n_i,

	// APB slave
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  gpio_pkg::apb_addr_t paddr_i,
	input  gpio_pkg::apb_data_t pwdata_i,
	output gpio_pkg::apb_data_t prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,

	// Pads
	output gpio_pkg::pad_vec_t  padout_o,
	output gpio_pkg::pad_vec_t  padoe_o,
	input  gpio_pkg::pad_vec_t  padin_i,

	// Peripheral signals
	input  logic                lcd_pwm_i,
	input  logic                uart_tx_i,
	input  logic                spi_sclk_i,
	input  logic                spi_cs_i,
	input  logic                spi_sdo_i,
	output logic                uart_rx_o,
	output logic                spi_sdi_o
);

	`include "gpio_pinmap.svh"

	// Pads that a peripheral drives when selected
	localparam gpio_pkg::pad_vec_t PERIPH_OE_MASK =
		(gpio_pkg::pad_vec_t'(1) << PIN_UART_TX)    |
		(gpio_pkg::pad_vec_t'(1) << PIN_FLASH_CS)   |
		(gpio_pkg::pad_vec_t'(1) << PIN_FLASH_SCLK) |
		(gpio_pkg::pad_vec_t'(1) << PIN_FLASH_MOSI) |
		(gpio_pkg::pad_vec_t'(1) << PIN_LCD_PWM);

	logic rst_n_sync;

	gpio_pkg::pad_vec_t sw_out;
	gpio_pkg::pad_vec_t sw_oe;
	gpio_pkg::pad_vec_t fsel;
	gpio_pkg::pad_vec_t periph_out;
	gpio_pkg::pad_vec_t padin_q;

	reset_sync u_reset_sync (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.rst_n_sync_o (rst_n_sync)
	);

	gpio_regs u_gpio_regs (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pslverr_o  (pslverr_o),
		.out_o      (sw_out),
		.dir_o      (sw_oe),
		.fsel_o     (fsel),
		.in_i       (padin_q)
	);

	// No wait states
	assign pready_o = 1'b1;

	// Peripheral output levels placed on their pads, 0 everywhere else
	always_comb begin
		periph_out                 = '0;
		periph_out[PIN_UART_TX]    = uart_tx_i;
		periph_out[PIN_FLASH_CS]   = spi_cs_i;
		periph_out[PIN_FLASH_SCLK] = spi_sclk_i;
		periph_out[PIN_FLASH_MOSI] = spi_sdo_i;
		periph_out[PIN_LCD_PWM]    = lcd_pwm_i;
	end

	// Per-pad mux, software when fsel is 0, peripheral when 1
	assign padout_o = (~fsel & sw_out) | (fsel & periph_out);
	assign padoe_o  = (~fsel & sw_oe)  | (fsel & PERIPH_OE_MASK);

	// Pad snapshot for the IN register and the UART receiver
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			padin_q <= '0;
		end else begin
			padin_q <= padin_i;
		end
	end

	// UART tolerates a cycle of latency, SPI sampling does not
	assign uart_rx_o = padin_q[PIN_UART_RX];
	assign spi_sdi_o = padin_i[PIN_FLASH_MISO];

	// Selected pads without an output peripheral stay undriven
	assert property (@(posedge clk) disable iff (!rst_n_sync)
		(padoe_o & fsel & ~PERIPH_OE_MASK) == '0)
		else $error("Output enable on a selected pad with no output peripheral");

endmodule

/* logic/gpio_regs.sv */
/* GPIO register block: APB slave holding OUT, DIR and FSEL,
   with a read port for the pad input snapshot and error responses */

module gpio_regs (
	input  logic                clk,
	input  logic                rst_n_sync,

	// APB slave, always ready
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  gpio_pkg::apb_addr_t paddr_i,
	input  gpio_pkg::apb_data_t pwdata_i,
	output gpio_pkg::apb_data_t prdata_o,
	output logic                pslverr_o,

	// Register outputs to the pad mux
	output gpio_pkg::pad_vec_t  out_o,
	output gpio_pkg::pad_vec_t  dir_o,
	output gpio_pkg::pad_vec_t  fsel_o,

	// Registered pad inputs
	input  gpio_pkg::pad_vec_t  in_i
);

	logic access;
	logic hit_out;
	logic hit_dir;
	logic hit_in;
	logic hit_fsel;
	logic addr_ok;
	logic err;
	logic wr_en;
	logic rd_en;

	gpio_pkg::pad_vec_t out_q;
	gpio_pkg::pad_vec_t dir_q;
	gpio_pkg::pad_vec_t fsel_q;
	gpio_pkg::pad_vec_t wdata;

	// Access phase completes in one cycle since pready is always high
	assign access = psel_i && penable_i;

	// Address decode
	assign hit_out  = (paddr_i == gpio_pkg::ADDR_OUT);
	assign hit_dir  = (paddr_i == gpio_pkg::ADDR_DIR);
	assign hit_in   = (paddr_i == gpio_pkg::ADDR_IN);
	assign hit_fsel = (paddr_i == gpio_pkg::ADDR_FSEL);
	assign addr_ok  = hit_out || hit_dir || hit_in || hit_fsel;

	// Unmapped offset, or a write to the read-only IN register
	assign err = access && (!addr_ok || (pwrite_i && hit_in));

	// Erroring accesses must not touch any register
	assign wr_en = access && pwrite_i && !err;
	assign rd_en = access && !pwrite_i;

	// Upper write data bits have no pads behind them
	assign wdata = pwdata_i[gpio_pkg::N_PADS-1:0];

	// OUT
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			out_q <= '0;
		end else if (wr_en && hit_out) begin
			out_q <= wdata;
		end
	end

	// DIR
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			dir_q <= '0;
		end else if (wr_en && hit_dir) begin
			dir_q <= wdata;
		end
	end

	// FSEL
	always_ff @(posedge clk or negedge rst_n_sync) begin
		if (!rst_n_sync) begin
			fsel_q <= '0;
		end else if (wr_en && hit_fsel) begin
			fsel_q <= wdata;
		end
	end

	// Read mux, registers zero-extended onto the data bus
	always_comb begin
		prdata_o = '0;
		if (rd_en) begin
			if (hit_out) begin
				prdata_o = gpio_pkg::apb_data_t'(out_q);
			end else if (hit_dir) begin
				prdata_o = gpio_pkg::apb_data_t'(dir_q);
			end else if (hit_in) begin
				prdata_o = gpio_pkg::apb_data_t'(in_i);
			end else if (hit_fsel) begin
				prdata_o = gpio_pkg::apb_data_t'(fsel_q);
			end
		end
	end

	assign pslverr_o = err;

	assign out_o  = out_q;
	assign dir_o  = dir_q;
	assign fsel_o = fsel_q;

	// Error response only ever appears in the access phase
	assert property (@(posedge clk) disable iff (!rst_n_sync)
		pslverr_o |-> (psel_i && penable_i))
		else $error("pslverr_o high outside an APB access phase");

	// A rejected write leaves every register as it was
	assert property (@(posedge clk) disable iff (!rst_n_sync)
		(pslverr_o && pwrite_i) |=> ($stable(out_q) && $stable(dir_q) && $stable(fsel_q)))
		else $error("Register changed after an error write");

endmodule

/* logic/reset_sync.sv */
/* Reset synchronizer: asserts asynchronously,
   releases two rising clock edges after the external reset rises */

module reset_sync (
	input  logic clk,
	input  logic rst_n_i,
	output logic rst_n_sync_o
);

	logic [1:0] sync_q;

	// Ones shift in once the external reset goes away
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign rst_n_sync_o = sync_q[1];

endmodule

/* logic/gpio_pkg.sv */
/* GPIO package: pad count, APB widths, register offsets
   and the vector types shared by the pad-control RTL */

package gpio_pkg;

	// Pad count and bus widths
	localparam int N_PADS = 23;
	localparam int W_ADDR = 16;
	localparam int W_DATA = 32;

	// Enough bits to name any pad
	localparam int W_PAD_IDX = $clog2(N_PADS);

	// One bit per pad, for values, enables and function selects
	typedef logic [N_PADS-1:0] pad_vec_t;

	// APB address and data
	typedef logic [W_ADDR-1:0] apb_addr_t;
	typedef logic [W_DATA-1:0] apb_data_t;

	// Pad index
	typedef logic [W_PAD_IDX-1:0] pad_idx_t;

	// Register map
	// OUT: software output value
	localparam apb_addr_t ADDR_OUT  = 16'h0000;
	// DIR: software output enable
	localparam apb_addr_t ADDR_DIR  = 16'h0004;
	// IN: registered pad snapshot, read-only
	localparam apb_addr_t ADDR_IN   = 16'h0008;
	// FSEL: 1 hands the pad to its peripheral
	localparam apb_addr_t ADDR_FSEL = 16'h000C;

endpackage

/* include/gpio_pinmap.svh */
/* GPIO pin map: the pad that each fixed peripheral signal uses.
   Included inside a module body, so every includer gets its own copy. */

// Outputs driven by peripherals when the pad's fsel bit is set
localparam gpio_pkg::pad_idx_t PIN_UART_TX    = 0;
localparam gpio_pkg::pad_idx_t PIN_FLASH_CS   = 2;
localparam gpio_pkg::pad_idx_t PIN_FLASH_SCLK = 3;
localparam gpio_pkg::pad_idx_t PIN_FLASH_MOSI = 4;
localparam gpio_pkg::pad_idx_t PIN_LCD_PWM    = 6;

// Inputs routed back to peripherals
// With fsel set these pads are inputs only
localparam gpio_pkg::pad_idx_t PIN_UART_RX    = 1;
localparam gpio_pkg::pad_idx_t PIN_FLASH_MISO = 5;
